/* design/cpuPkg.sv */
package cpuPkg;

    // ========================================
    // widths with a meaning
    // ========================================
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // ========================================
    // opcodes of the supported subset
    // ========================================
    localparam opcode_t opLui    = 7'd55;
    localparam opcode_t opRtype  = 7'd51;
    localparam opcode_t opItype  = 7'd19;
    localparam opcode_t opBranch = 7'd99;
    localparam opcode_t opJalr   = 7'd103;
    localparam opcode_t opJal    = 7'd111;
    localparam opcode_t opLoad   = 7'd3;
    localparam opcode_t opStore  = 7'd35;

    localparam funct3_t f3Add  = 3'b000;   // also addi
    localparam funct3_t f3Sll  = 3'b001;
    localparam funct3_t f3Xor  = 3'b100;
    localparam funct3_t f3Srl  = 3'b101;
    localparam funct3_t f3And  = 3'b111;
    localparam funct3_t f3Word = 3'b010;   // lw and sw
    localparam funct3_t f3Beq  = 3'b000;
    localparam funct3_t f3Bne  = 3'b001;

    // alu codes match funct3 of the r-type ops
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSll = 3'b001,
        aluXor = 3'b100,
        aluSrl = 3'b101,
        aluAnd = 3'b111
    } aluOp_t;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSel_t;

    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4, resImm} resultSel_t;

    typedef enum logic [1:0] {pcPlus4, pcTarget, pcAlu} pcSel_t;

endpackage

/* design/ctrlIf.sv */
`timescale 1ns/1ns

interface ctrlIf;
    import cpuPkg::*;

    pcSel_t     pcSel;
    resultSel_t resultSel;
    logic       memWrite;
    aluOp_t     aluOp;
    logic       aluSrcImm;      // second operand is the immediate
    immSel_t    immSel;
    logic       regWrite;

    modport decoder (
        output pcSel, resultSel, memWrite, aluOp, aluSrcImm, immSel, regWrite
    );

    modport fetch   (input pcSel);
    modport execute (input aluOp, aluSrcImm, immSel);
    modport memory  (input memWrite, resultSel);
    modport regs    (input regWrite);

endinterface

/* design/fetchUnit.sv */
`timescale 1ns/1ns

module fetchUnit #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  logic          clk,
    input  logic          rstN,
    ctrlIf.fetch          ctrl,
    input  cpuPkg::word_t immExt,
    input  cpuPkg::word_t aluResult,
    output cpuPkg::word_t pc,
    output cpuPkg::word_t pcPlus4,
    output logic          instrValid
);
    import cpuPkg::*;

    word_t pcTargetAddr;
    word_t pcNext;

    assign pcPlus4      = pc + 32'd4;
    assign pcTargetAddr = pc + immExt;      // branch and jal target

    always_comb begin
        case (ctrl.pcSel)
            pcTarget: pcNext = pcTargetAddr;
            pcAlu:    pcNext = {aluResult[31:1], 1'b0};   // jalr clears bit 0
            default:  pcNext = pcPlus4;
        endcase
    end

    // first edge after reset only raises instrValid, pc stays on resetPc
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= resetPc;
            instrValid <= 1'b0;
        end else begin
            instrValid <= 1'b1;
            if (instrValid) begin
                pc <= pcNext;
            end
        end
    end

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ns

module controlUnit (
    input  cpuPkg::instr_t instr,
    input  logic           instrValid,
    input  logic           zero,
    ctrlIf.decoder         ctrl
);
    import cpuPkg::*;

    opcode_t opcode;
    funct3_t funct3;
    pcSel_t  pcSelDec;      // jump select before branch resolution
    logic    isBeq;
    logic    isBne;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // ========================================
    // opcode / funct3 decode
    // ========================================
    always_comb begin
        pcSelDec       = pcPlus4;     // unknown encodings leave all inactive
        isBeq          = 1'b0;
        isBne          = 1'b0;
        ctrl.resultSel = resAlu;
        ctrl.memWrite  = 1'b0;
        ctrl.aluOp     = aluAdd;
        ctrl.aluSrcImm = 1'b0;
        ctrl.immSel    = immI;
        ctrl.regWrite  = 1'b0;

        case (opcode)
            opLui: begin
                ctrl.immSel    = immU;
                ctrl.resultSel = resImm;    // straight from the immediate
                ctrl.regWrite  = 1'b1;
            end
            opRtype: begin
                case (funct3)
                    f3Add, f3Sll, f3Xor, f3Srl, f3And: begin
                        ctrl.aluOp    = aluOp_t'(funct3);
                        ctrl.regWrite = 1'b1;
                    end
                    default: ;              // do nothing
                endcase
            end
            opItype: begin
                case (funct3)
                    f3Add: begin            // addi
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.regWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end
            opBranch: begin
                ctrl.immSel = immB;
                ctrl.aluOp  = aluXor;       // equal operands give zero
                case (funct3)
                    f3Beq:   isBeq = 1'b1;
                    f3Bne:   isBne = 1'b1;
                    default: ;
                endcase
            end
            opJalr: begin
                pcSelDec       = pcAlu;     // rs1 + imm
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = resPcPlus4;
                ctrl.regWrite  = 1'b1;
            end
            opJal: begin
                pcSelDec       = pcTarget;
                ctrl.immSel    = immJ;
                ctrl.resultSel = resPcPlus4; // return address
                ctrl.regWrite  = 1'b1;
            end
            opLoad: begin
                case (funct3)
                    f3Word: begin           // lw
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.resultSel = resMem;
                        ctrl.regWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end
            opStore: begin
                case (funct3)
                    f3Word: begin           // sw
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.immSel    = immS;
                        ctrl.memWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase

        if (!instrValid) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    // ========================================
    // branch resolution
    // ========================================
    always_comb begin
        if (!instrValid) begin
            ctrl.pcSel = pcPlus4;
        end else if ((isBeq && zero) || (isBne && !zero)) begin
            ctrl.pcSel = pcTarget;
        end else begin
            ctrl.pcSel = pcSelDec;
        end
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic             clk,
    input  logic             rstN,
    ctrlIf.regs              ctrl,
    input  cpuPkg::regAddr_t rs1Addr,
    input  cpuPkg::regAddr_t rs2Addr,
    input  cpuPkg::regAddr_t rdAddr,
    input  cpuPkg::word_t    writeData,
    output cpuPkg::word_t    rs1Data,
    output cpuPkg::word_t    rs2Data
);
    import cpuPkg::*;

    word_t regs [32];

    // x0 reads zero whatever the array holds
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && rdAddr != '0) begin
            regs[rdAddr] <= writeData;
        end
    end

endmodule

/* design/executeUnit.sv */
`timescale 1ns/1ns

module executeUnit (
    ctrlIf.execute         ctrl,
    input  cpuPkg::instr_t instr,
    input  cpuPkg::word_t  rs1Data,
    input  cpuPkg::word_t  rs2Data,
    output cpuPkg::word_t  immExt,
    output cpuPkg::word_t  aluResult,
    output logic           zero
);
    import cpuPkg::*;

    word_t srcB;

    // ========================================
    // immediate extension
    // ========================================
    always_comb begin
        case (ctrl.immSel)
            immS: begin
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                immExt = {{19{instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            end
            immU: begin
                immExt = {instr[31:12], 12'b0};
            end
            immJ: begin
                immExt = {{11{instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            end
            default: begin          // I-type
                immExt = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

    // ========================================
    // operand select and ALU
    // ========================================
    assign srcB = ctrl.aluSrcImm ? immExt : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            aluSll:  aluResult = rs1Data << srcB[4:0];
            aluXor:  aluResult = rs1Data ^ srcB;
            aluSrl:  aluResult = rs1Data >> srcB[4:0];
            aluAnd:  aluResult = rs1Data & srcB;
            default: aluResult = rs1Data + srcB;   // add, address calc
        endcase
    end

    assign zero = (aluResult == '0);   // branch compare via xor

endmodule

/* design/dataMemory.sv */
`timescale 1ns/1ns

module dataMemory #(
    parameter int memDepth = 256
) (
    input  logic          clk,
    input  logic          rstN,
    ctrlIf.memory         ctrl,
    input  cpuPkg::word_t aluResult,
    input  cpuPkg::word_t storeData,
    input  cpuPkg::word_t pcPlus4,
    input  cpuPkg::word_t immExt,
    output cpuPkg::word_t readData,
    output cpuPkg::word_t result
);
    import cpuPkg::*;

    localparam int addrBits = $clog2(memDepth);

    word_t                ram [memDepth];
    logic  [addrBits-1:0] wordAddr;

    assign wordAddr = aluResult[addrBits+1:2];   // word aligned, byte bits dropped
    assign readData = ram[wordAddr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < memDepth; i++) begin
                ram[i] <= '0;
            end
        end else if (ctrl.memWrite) begin
            ram[wordAddr] <= storeData;
        end
    end

    // writeback select
    always_comb begin
        case (ctrl.resultSel)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4;
            resImm:     result = immExt;
            default:    result = aluResult;
        endcase
    end

endmodule

/* design/riscCore.sv */
`timescale 1ns/1ns

module riscCore #(
    parameter int            memDepth = 256,
    parameter cpuPkg::word_t resetPc  = '0
) (
    input  logic             clk,
    input  logic             rstN,
    output cpuPkg::word_t    pc,
    input  cpuPkg::instr_t   instr,
    output logic             regWriteEn,
    output cpuPkg::regAddr_t regWriteAddr,
    output cpuPkg::word_t    regWriteData,
    output logic             memWriteEn,
    output cpuPkg::word_t    memAddr,
    output cpuPkg::word_t    memWriteData
);
    import cpuPkg::*;

    logic  instrValid;
    logic  zero;
    word_t pcPlus4;
    word_t immExt;
    word_t rs1Data;

    ctrlIf ctrlBus ();

    // retire view for the outside
    assign regWriteEn   = ctrlBus.regWrite;
    assign regWriteAddr = instr[11:7];
    assign memWriteEn   = ctrlBus.memWrite;

    // ========================================
    fetchUnit #(.resetPc(resetPc)) uFetch (
        .clk, .rstN, .ctrl(ctrlBus), .immExt, .aluResult(memAddr),
        .pc, .pcPlus4, .instrValid
    );

    controlUnit uControl (.instr, .instrValid, .zero, .ctrl(ctrlBus));

    regFile uRegs (
        .clk, .rstN, .ctrl(ctrlBus), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rdAddr(regWriteAddr), .writeData(regWriteData), .rs1Data, .rs2Data(memWriteData)
    );

    executeUnit uExecute (
        .ctrl(ctrlBus), .instr, .rs1Data, .rs2Data(memWriteData),
        .immExt, .aluResult(memAddr), .zero
    );

    dataMemory #(.memDepth(memDepth)) uMemory (
        .clk, .rstN, .ctrl(ctrlBus), .aluResult(memAddr), .storeData(memWriteData),
        .pcPlus4, .immExt, .readData(), .result(regWriteData)
    );

endmodule

/* test/riscCoreModel.svh */
`ifndef RISC_CORE_MODEL_SVH
`define RISC_CORE_MODEL_SVH

// ========================================
// RV32I encoders
// ========================================
localparam int isaLoad   = 'h03;
localparam int isaOpImm  = 'h13;
localparam int isaStore  = 'h23;
localparam int isaOpReg  = 'h33;
localparam int isaLui    = 'h37;
localparam int isaBranch = 'h63;
localparam int isaJalr   = 'h67;
localparam int isaJal    = 'h6f;

localparam int modelMemWords = 256;     // byte address bits 9:2 pick the word

function automatic instr_t rType(input int f3, rd, rs1, rs2);
    return {7'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], isaOpReg[6:0]};
endfunction

function automatic instr_t iType(input int op, f3, rd, rs1, imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic instr_t sType(input int rs1, rs2, imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], isaStore[6:0]};
endfunction

function automatic instr_t bType(input int f3, rs1, rs2, imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            isaBranch[6:0]};
endfunction

function automatic instr_t uType(input int rd, imm);
    return {imm[19:0], rd[4:0], isaLui[6:0]};
endfunction

function automatic instr_t jType(input int rd, imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], isaJal[6:0]};
endfunction

// ========================================
// reference ISA model
// ========================================
word_t    refPc;
word_t    refRegs [32];
word_t    refMem [modelMemWords];
logic     modelValid;       // follows the core's first idle edge
word_t    nextPc;
word_t    expPc;
logic     expRegWe;
regAddr_t expRegAddr;
word_t    expRegData;
logic     expMemWe;
word_t    expMemAddr;
word_t    expMemData;

task automatic resetModel();
    refPc      = '0;
    expPc      = '0;
    modelValid = 1'b0;
    expRegWe   = 1'b0;
    expMemWe   = 1'b0;
    foreach (refRegs[i]) begin
        refRegs[i] = '0;
    end
    foreach (refMem[i]) begin
        refMem[i] = '0;
    end
endtask

// expected retire view of one instruction word
task automatic predictRetire(input instr_t ins);
    int    op;
    int    f3;
    word_t a;
    word_t b;
    word_t iImm;
    word_t loadAddr;
    op         = int'(ins[6:0]);
    f3         = int'(ins[14:12]);
    a          = refRegs[ins[19:15]];
    b          = refRegs[ins[24:20]];
    iImm       = {{20{ins[31]}}, ins[31:20]};
    loadAddr   = a + iImm;
    expPc      = refPc;
    expRegWe   = 1'b0;
    expRegAddr = ins[11:7];
    expRegData = '0;
    expMemWe   = 1'b0;
    expMemAddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
    expMemData = b;
    nextPc     = refPc + 32'd4;
    if (modelValid) begin
        case (op)
            isaOpReg: begin
                expRegWe = 1'b1;
                case (f3)
                    0:       expRegData = a + b;
                    1:       expRegData = a << b[4:0];
                    4:       expRegData = a ^ b;
                    5:       expRegData = a >> b[4:0];
                    7:       expRegData = a & b;
                    default: expRegWe = 1'b0;
                endcase
            end
            isaOpImm: begin
                expRegWe   = (f3 == 0);         // addi only
                expRegData = a + iImm;
            end
            isaLui: begin
                expRegWe   = 1'b1;
                expRegData = {ins[31:12], 12'b0};
            end
            isaLoad: begin
                expRegWe   = (f3 == 2);         // lw only
                expRegData = refMem[loadAddr[9:2]];
            end
            isaStore: expMemWe = (f3 == 2);
            isaBranch: begin
                if ((f3 == 0 && a == b) || (f3 == 1 && a != b)) begin
                    nextPc = refPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                      ins[11:8], 1'b0};
                end
            end
            isaJal: begin
                expRegWe   = 1'b1;
                expRegData = refPc + 32'd4;
                nextPc     = refPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
            end
            isaJalr: begin
                expRegWe   = 1'b1;
                expRegData = refPc + 32'd4;
                nextPc     = (a + iImm) & ~32'd1;
            end
            default: ;                          // no effect, pc moves on
        endcase
    end
endtask

task automatic commitRetire();
    if (expRegWe && expRegAddr != '0) begin
        refRegs[expRegAddr] = expRegData;
    end
    if (expMemWe) begin
        refMem[expMemAddr[9:2]] = expMemData;
    end
    refPc = nextPc;
endtask

`endif

/* test/riscCoreTb.sv */
`timescale 1ns/1ns

module riscCoreTb;
    import cpuPkg::*;

    localparam int     maxCycles = 200;
    localparam instr_t nopWord   = 32'h0000_0013;   // addi x0, x0, 0

    logic     clk;
    logic     rstN;
    word_t    pc;
    instr_t   instr;
    logic     regWriteEn;
    regAddr_t regWriteAddr;
    word_t    regWriteData;
    logic     memWriteEn;
    word_t    memAddr;
    word_t    memWriteData;

    instr_t prog [$];
    word_t  endPc;
    int     errorCount;
    int     cycles;
    logic   timedOut;

    `include "riscCoreModel.svh"

    riscCore #(.memDepth(modelMemWords), .resetPc(32'h0)) u_dut (
        .clk, .rstN, .pc, .instr, .regWriteEn, .regWriteAddr, .regWriteData,
        .memWriteEn, .memAddr, .memWriteData
    );

    always #50 clk = ~clk;

    // ========================================
    // retire checks
    // ========================================
    resetQuiet: assert property (@(posedge clk) rstN || (!regWriteEn && !memWriteEn))
        else begin
            errorCount++;
            $display("ERROR %0t: write enable high during reset", $time);
        end

    pcCheck: assert property (@(posedge clk) disable iff (!rstN) pc == expPc)
        else begin
            errorCount++;
            $display("ERROR %0t: pc %h, expected %h", $time, $sampled(pc), expPc);
        end

    regWriteCheck: assert property (@(posedge clk) disable iff (!rstN)
        regWriteEn == expRegWe
        && (!expRegWe || (regWriteAddr == expRegAddr && regWriteData == expRegData)))
        else begin
            errorCount++;
            $display("ERROR %0t: reg write %b x%0d %h, expected %b x%0d %h", $time,
                     $sampled(regWriteEn), $sampled(regWriteAddr), $sampled(regWriteData),
                     expRegWe, expRegAddr, expRegData);
        end

    memWriteCheck: assert property (@(posedge clk) disable iff (!rstN)
        memWriteEn == expMemWe
        && (!expMemWe || (memAddr == expMemAddr && memWriteData == expMemData)))
        else begin
            errorCount++;
            $display("ERROR %0t: store %b @%h %h, expected %b @%h %h", $time,
                     $sampled(memWriteEn), $sampled(memAddr), $sampled(memWriteData),
                     expMemWe, expMemAddr, expMemData);
        end

    function automatic instr_t fetchWord(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx >= 0 && idx < prog.size()) begin
            return prog[idx];
        end
        return nopWord;     // outside the program
    endfunction

    task automatic advanceCycle(input logic valid);
        if (modelValid) begin
            commitRetire();
        end
        modelValid = valid;
        instr = fetchWord(pc);
        predictRetire(instr);
    endtask

    task automatic buildProgram();
        word_t a;
        word_t b;
        int    target;
        a = $urandom();
        b = $urandom();
        // x1 and x2 built by lui and addi with a carry for the low part
        prog.push_back(uType(1, int'(a[31:12]) + int'(a[11])));
        prog.push_back(iType(isaOpImm, 0, 1, 1, int'(a[11:0])));
        prog.push_back(uType(2, int'(b[31:12]) + int'(b[11])));
        prog.push_back(iType(isaOpImm, 0, 2, 2, int'(b[11:0])));
        prog.push_back(rType(0, 3, 1, 2));      // add
        prog.push_back(rType(1, 4, 1, 2));      // sll
        prog.push_back(rType(4, 5, 1, 2));      // xor
        prog.push_back(rType(5, 6, 1, 2));      // srl
        prog.push_back(rType(7, 7, 1, 2));      // and
        prog.push_back(iType(isaOpImm, 0, 8, 1, int'($urandom_range(0, 4095))));
        prog.push_back(iType(isaOpImm, 0, 0, 1, 123));     // write to x0
        prog.push_back(rType(0, 9, 0, 1));      // x9 = x0 + x1
        prog.push_back(iType(isaOpImm, 0, 10, 0, 64));     // store base
        prog.push_back(sType(10, 3, 8));
        prog.push_back(sType(10, 5, -4));
        prog.push_back(iType(isaLoad, 2, 11, 10, 8));
        prog.push_back(iType(isaLoad, 2, 12, 10, -4));
        prog.push_back(bType(0, 1, 9, 8));      // beq taken
        prog.push_back(iType(isaOpImm, 0, 13, 0, 1));
        prog.push_back(bType(0, 1, 2, 8));      // beq not taken
        prog.push_back(bType(1, 1, 2, 8));      // bne taken
        prog.push_back(iType(isaOpImm, 0, 13, 0, 2));
        prog.push_back(bType(1, 1, 9, 8));      // bne not taken
        prog.push_back(jType(14, 8));
        prog.push_back(iType(isaOpImm, 0, 13, 0, 3));
        target = (prog.size() + 4) * 4;
        prog.push_back(iType(isaOpImm, 0, 15, 0, target - 4));
        prog.push_back(iType(isaJalr, 0, 16, 15, 5));      // odd sum loses bit 0
        prog.push_back(iType(isaOpImm, 0, 13, 0, 4));
        prog.push_back(iType(isaOpImm, 0, 13, 0, 5));
        prog.push_back(iType(isaLoad, 0, 17, 10, 8));      // lb is not supported
        prog.push_back(32'h0000_0000);
        prog.push_back(rType(0, 18, 11, 12));
        endPc = prog.size() * 4;
        prog.push_back(jType(0, 0));            // end marker jumping to itself
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instr      = nopWord;   // decodes to a register write
        errorCount = 0;
        timedOut   = 1'b0;
        void'($urandom(32'he037_628b));
        buildProgram();
        resetModel();
        @(posedge clk);
        @(negedge clk);
        instr = sType(0, 0, 0); // decodes to a store
        @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        advanceCycle(1'b0);     // first edge only raises the valid flag
        cycles = 0;
        while (pc != endPc && cycles < maxCycles) begin
            @(negedge clk);
            advanceCycle(1'b1);
            cycles++;
        end
        if (pc != endPc) begin
            timedOut = 1'b1;
            $display("Timeout: program end marker not reached within %0d cycles", maxCycles);
        end else begin
            repeat (2) begin    // a few turns of the end loop
                @(negedge clk);
                advanceCycle(1'b1);
            end
            @(negedge clk);
        end
        $display("Errors: %0d, timeouts: %0d", errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* riscCore.f */
+incdir+test
design/cpuPkg.sv
design/ctrlIf.sv
design/fetchUnit.sv
design/controlUnit.sv
design/regFile.sv
design/executeUnit.sv
design/dataMemory.sv
design/riscCore.sv
test/riscCoreTb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := riscCoreTb
FILELIST := riscCore.f
OBJDIR   := obj_dir
LOG      := sim.log
FAILMSG  := Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
